/* build.f */
hdl/eth_stats_frame_pkg.sv
hdl/eth_stats_reg_pkg.sv
hdl/eth_stats_counter_tx.sv
hdl/eth_stats_counter_rx.sv
hdl/eth_stats_adder.sv
hdl/eth_stats_wb_regs.sv
hdl/eth_stats_collector.sv
tests/eth_stats_collector_assert.sv
tests/tb_eth_stats_collector.sv

/* tests/tb_eth_stats_collector.sv */
// Testbench for the Ethernet statistics collector.
// Applies a table of frames and register operations, keeps a model of the
// totals and tags, and checks them over the Wishbone port.

`timescale 1ns/1ps
`default_nettype none

module tb_eth_stats_collector import eth_stats_reg_pkg::*, eth_stats_frame_pkg::*;;

	localparam int clk_period    = 40;
	localparam int counter_width = 64;
	localparam int frame_latency = 2;
	localparam int ack_timeout   = 16;

	localparam logic [1:0] op_tx   = 2'd0;
	localparam logic [1:0] op_rx   = 2'd1;
	localparam logic [1:0] op_srst = 2'd2;
	localparam logic [1:0] op_snap = 2'd3;

	typedef struct packed {
		logic [1:0]  op;
		logic [15:0] len;
		logic        bad;
		logic        en;
		logic        tr;
	} entry_t;

	localparam int num_entries = 29;
	localparam int watchdog_cycles = num_entries * 2000 + 1000;

	// Operation, length, inject bad, enable bit, time_running.
	entry_t frames [num_entries] = '{
		'{op_tx, 16'd64, 1'b0, 1'b1, 1'b1},   '{op_rx, 16'd60, 1'b0, 1'b1, 1'b1},
		'{op_tx, 16'd128, 1'b0, 1'b1, 1'b1},  '{op_rx, 16'd1000, 1'b0, 1'b1, 1'b1},
		'{op_tx, 16'd10, 1'b1, 1'b1, 1'b1},   '{op_rx, 16'd72, 1'b1, 1'b1, 1'b1},
		'{op_tx, 16'd40, 1'b0, 1'b0, 1'b1},   '{op_rx, 16'd50, 1'b0, 1'b1, 1'b0},
		'{op_tx, 16'd20, 1'b1, 1'b0, 1'b0},   '{op_rx, 16'd30, 1'b1, 1'b0, 1'b1},
		'{op_snap, 16'd30, 1'b0, 1'b1, 1'b1}, '{op_rx, 16'd1, 1'b0, 1'b1, 1'b1},
		'{op_tx, 16'd2, 1'b1, 1'b1, 1'b1},    '{op_tx, 16'd300, 1'b0, 1'b1, 1'b1},
		'{op_rx, 16'd12, 1'b1, 1'b1, 1'b1},   '{op_tx, 16'd5, 1'b1, 1'b1, 1'b1},
		'{op_rx, 16'd800, 1'b0, 1'b1, 1'b1},  '{op_tx, 16'd46, 1'b0, 1'b1, 1'b1},
		'{op_rx, 16'd3, 1'b0, 1'b1, 1'b1},    '{op_tx, 16'd9, 1'b0, 1'b1, 1'b1},
		'{op_rx, 16'd33, 1'b0, 1'b1, 1'b1},   '{op_tx, 16'd1, 1'b0, 1'b1, 1'b1},
		'{op_rx, 16'd64, 1'b1, 1'b1, 1'b1},   '{op_tx, 16'd777, 1'b0, 1'b1, 1'b1},
		'{op_srst, 16'd0, 1'b0, 1'b1, 1'b1},  '{op_tx, 16'd100, 1'b0, 1'b1, 1'b1},
		'{op_rx, 16'd200, 1'b1, 1'b1, 1'b1},  '{op_srst, 16'd0, 1'b0, 1'b0, 1'b1},
		'{op_tx, 16'd50, 1'b0, 1'b1, 1'b1}
	};

	logic clk, rst_n, time_running;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [wb_addr_width-1:0] wb_adr;
	logic [wb_data_width-1:0] wb_dat_w, wb_dat_r;
	logic tx_tvalid, tx_tready, tx_tlast;
	logic rx_tvalid, rx_tlast, rx_tuser;

	// Reference model. Index 0 is transmit and index 1 is receive.
	logic [counter_width-1:0] exp_bytes [2];
	logic [counter_width-1:0] exp_good [2];
	logic [counter_width-1:0] exp_bad [2];
	logic [tag_width-1:0]     exp_tag [2];
	logic                     enabled;
	int                       errors = 0;

	eth_stats_collector #(.counter_width(counter_width)) UUT (
		.clk(clk), .rst_n(rst_n), .time_running(time_running),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tlast(tx_tlast),
		.rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tuser(rx_tuser)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus and stream drivers
	////////////////////////////////////////////////////////////////////////////

	// Called on a falling edge. Returns on the falling edge where ack was seen.
	task automatic wb_access(input logic we, input logic [wb_addr_width-1:0] adr,
			input logic [wb_data_width-1:0] wdat, output logic [wb_data_width-1:0] rdat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < ack_timeout);
		assert (wb_ack) else begin
			errors++;
			$display("Wishbone access to word %0d was never acknowledged", adr);
		end
		rdat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic send_tx(input int len, input logic bad);
		int i;
		repeat ($urandom % 4) @(negedge clk);
		for (i = 0; i < len; i++) begin
			if (bad && i == 1) begin
				// A dry cycle inside the frame is an underrun.
				tx_tvalid = 1'b0;
				@(negedge clk);
			end
			tx_tlast = (i == len - 1);
			if ($urandom % 4 == 0) begin
				tx_tvalid = 1'b1;
				tx_tready = 1'b0;
				repeat (1 + $urandom % 2) @(negedge clk);
			end
			tx_tvalid = 1'b1;
			tx_tready = 1'b1;
			@(negedge clk);
		end
		tx_tvalid = 1'b0;
		tx_tlast = 1'b0;
	endtask

	task automatic send_rx(input int len, input logic bad);
		int i;
		repeat ($urandom % 4) @(negedge clk);
		for (i = 0; i < len; i++) begin
			if ($urandom % 4 == 0) begin
				rx_tvalid = 1'b0;
				@(negedge clk);
			end
			rx_tvalid = 1'b1;
			rx_tlast = (i == len - 1);
			rx_tuser = bad && (i == len - 1);
			@(negedge clk);
		end
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		rx_tuser = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Model and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic count_frame(input int dir, input int len, input logic bad);
		exp_bytes[dir] += len;
		if (bad) begin
			exp_bad[dir] += 1;
		end else begin
			exp_good[dir] += 1;
		end
		exp_tag[dir] += 1'b1;
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic check_total(input logic [wb_addr_width-1:0] lo_adr,
			input logic [counter_width-1:0] exp);
		logic [wb_data_width-1:0] rd;
		wb_access(1'b0, lo_adr, '0, rd);
		check_word(rd, exp[31:0], $sformatf("total lo at word %0d", lo_adr));
		wb_access(1'b0, lo_adr + 1'b1, '0, rd);
		check_word(rd, exp[63:32], $sformatf("total hi at word %0d", lo_adr + 1'b1));
	endtask

	task automatic check_all();
		logic [wb_data_width-1:0] rd;
		logic [wb_data_width-1:0] exp;
		int d;
		wb_access(1'b0, reg_ctrl, '0, rd);
		exp = '0;
		exp[ctrl_enable_bit] = enabled;
		check_word(rd, exp, "control");
		wb_access(1'b0, reg_status, '0, rd);
		exp = '0;
		exp[status_tx_lsb +: tag_width] = exp_tag[0];
		exp[status_rx_lsb +: tag_width] = exp_tag[1];
		check_word(rd, exp, "status");
		for (d = 0; d < 2; d++) begin
			check_total(wb_addr_width'(reg_tx_bytes_lo + 6 * d), exp_bytes[d]);
			check_total(wb_addr_width'(reg_tx_good_lo + 6 * d), exp_good[d]);
			check_total(wb_addr_width'(reg_tx_bad_lo + 6 * d), exp_bad[d]);
		end
	endtask

	initial begin
		entry_t e;
		logic [wb_data_width-1:0] rd;
		logic [wb_data_width-1:0] wdat;
		logic [counter_width-1:0] snap;
		int n;
		void'($urandom(58));
		rst_n = 1'b0;
		time_running = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		tx_tvalid = 1'b0;
		tx_tready = 1'b1;
		tx_tlast = 1'b0;
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		rx_tuser = 1'b0;
		enabled = 1'b0;
		for (n = 0; n < 2; n++) begin
			exp_bytes[n] = '0;
			exp_good[n] = '0;
			exp_bad[n] = '0;
			exp_tag[n] = '0;
		end
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_all();

		for (n = 0; n < num_entries; n++) begin
			e = frames[n];
			time_running = e.tr;
			wdat = '0;
			wdat[ctrl_enable_bit] = e.en;
			wdat[ctrl_srst_bit] = (e.op == op_srst);
			wb_access(1'b1, reg_ctrl, wdat, rd);
			enabled = e.en;
			// The counting gate is registered, so let it settle first.
			repeat (2) @(negedge clk);
			if (e.op == op_srst) begin
				for (int d = 0; d < 2; d++) begin
					exp_bytes[d] = '0;
					exp_good[d] = '0;
					exp_bad[d] = '0;
					exp_tag[d] = '0;
				end
			end else begin
				if (e.op == op_snap) begin
					wb_access(1'b0, reg_tx_bytes_lo, '0, rd);
					snap = exp_bytes[0];
					check_word(rd, snap[31:0], "snapshot lo");
				end
				if (e.op == op_rx) begin
					send_rx(e.len, e.bad);
				end else begin
					send_tx(e.len, e.bad);
				end
				repeat (frame_latency) @(negedge clk);
				if (e.op == op_snap) begin
					// The hi word still belongs to the value seen by the lo read.
					wb_access(1'b0, reg_tx_bytes_hi, '0, rd);
					check_word(rd, snap[63:32], "snapshot hi");
					wb_access(1'b0, 4'd14, '0, rd);
					check_word(rd, '0, "unmapped word 14");
					wb_access(1'b0, 4'd15, '0, rd);
					check_word(rd, '0, "unmapped word 15");
					wb_access(1'b1, reg_status, '1, rd);
				end
				if (e.en && e.tr) begin
					count_frame((e.op == op_rx) ? 1 : 0, e.len, e.bad);
				end
			end
			check_all();
		end

		$display("Closing report: %0d mismatches, %0d assertion failures",
			errors, UUT.u_assert.error_count);
		if (errors == 0 && UUT.u_assert.error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/eth_stats_collector_assert.sv */
// Bound checks for the Ethernet statistics collector.
// Watches the Wishbone handshake and the per-direction update tags.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_collector_assert import eth_stats_frame_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_ack,
	input  logic                 srst,
	input  logic [tag_width-1:0] tx_id,
	input  logic [tag_width-1:0] rx_id
);

	int error_count = 0;

	// An ack answers a cycle that was pending on the edge before.
	ack_follows_request: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
	else begin
		error_count++;
		$error("Wishbone ack raised without a pending cycle");
	end

	ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
	else begin
		error_count++;
		$error("Wishbone ack held high for two cycles");
	end

	// Outside a software reset a tag only ever moves forward by one.
	tx_tag_steps: assert property (@(posedge clk) disable iff (!rst_n)
		(!$past(srst) && tx_id != $past(tx_id)) |-> tx_id == tag_width'($past(tx_id) + 1'b1))
	else begin
		error_count++;
		$error("Transmit update tag jumped by more than one");
	end

	rx_tag_steps: assert property (@(posedge clk) disable iff (!rst_n)
		(!$past(srst) && rx_id != $past(rx_id)) |-> rx_id == tag_width'($past(rx_id) + 1'b1))
	else begin
		error_count++;
		$error("Receive update tag jumped by more than one");
	end

endmodule

bind eth_stats_collector eth_stats_collector_assert u_assert (
	.clk(clk), .rst_n(rst_n),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.srst(srst), .tx_id(tx_id), .rx_id(rx_id)
);

`default_nettype wire

/* hdl/eth_stats_collector.sv */
// Ethernet traffic statistics collector.
// Counts bytes, good frames and bad frames on the MAC transmit and receive
// streams and exposes the totals on a Wishbone classic slave port.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_collector import eth_stats_reg_pkg::*, eth_stats_frame_pkg::*; #(
	parameter int counter_width = 64
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     time_running,

	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [wb_addr_width-1:0] wb_adr,
	input  logic [wb_data_width-1:0] wb_dat_w,
	output logic [wb_data_width-1:0] wb_dat_r,
	output logic                     wb_ack,

	input  logic                     tx_tvalid,
	input  logic                     tx_tready,
	input  logic                     tx_tlast,

	input  logic                     rx_tvalid,
	input  logic                     rx_tlast,
	input  logic                     rx_tuser
);

	logic                       enable;
	logic                       srst;
	logic                       count_enable;
	logic                       adder_rst_n;

	logic [tag_width-1:0]       tx_id;
	logic [tag_width-1:0]       rx_id;
	logic [counter_width-1:0]   tx_bytes, tx_good, tx_bad;
	logic [counter_width-1:0]   rx_bytes, rx_good, rx_bad;

	logic [frame_len_width-1:0] tx_frame_bytes;
	logic                       tx_frame_good;
	logic                       tx_valid;
	logic [frame_len_width-1:0] rx_frame_bytes;
	logic                       rx_frame_good;
	logic                       rx_valid;

	eth_stats_wb_regs #(.counter_width(counter_width)) u_regs (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.enable(enable), .srst(srst),
		.tx_id(tx_id), .rx_id(rx_id),
		.tx_bytes(tx_bytes), .tx_good(tx_good), .tx_bad(tx_bad),
		.rx_bytes(rx_bytes), .rx_good(rx_good), .rx_bad(rx_bad)
	);

	////////////////////////////////////////////////////////////////////////////
	// Counting gate and software reset
	////////////////////////////////////////////////////////////////////////////

	// The software reset clears the totals but leaves the frame counters alone.
	assign adder_rst_n = rst_n & ~srst;

	// Counting needs both the enable bit and a running time base.
	always_ff @(posedge clk) begin
		if (!adder_rst_n) begin
			count_enable <= 1'b0;
		end else begin
			count_enable <= enable & time_running;
		end
	end

	// Transmit direction.
	eth_stats_counter_tx u_counter_tx (
		.clk(clk), .rst_n(rst_n),
		.tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tlast(tx_tlast),
		.frame_bytes(tx_frame_bytes), .frame_good(tx_frame_good), .valid(tx_valid)
	);

	eth_stats_adder #(.counter_width(counter_width)) u_adder_tx (
		.clk(clk), .rst_n(adder_rst_n), .enable(count_enable),
		.valid(tx_valid), .frame_good(tx_frame_good), .frame_length(tx_frame_bytes),
		.total_bytes(tx_bytes), .total_good(tx_good), .total_bad(tx_bad),
		.stats_id(tx_id)
	);

	// Receive direction, on the same clock as transmit.
	eth_stats_counter_rx u_counter_rx (
		.clk(clk), .rst_n(rst_n),
		.rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tuser(rx_tuser),
		.frame_bytes(rx_frame_bytes), .frame_good(rx_frame_good), .valid(rx_valid)
	);

	eth_stats_adder #(.counter_width(counter_width)) u_adder_rx (
		.clk(clk), .rst_n(adder_rst_n), .enable(count_enable),
		.valid(rx_valid), .frame_good(rx_frame_good), .frame_length(rx_frame_bytes),
		.total_bytes(rx_bytes), .total_good(rx_good), .total_bad(rx_bad),
		.stats_id(rx_id)
	);

endmodule

`default_nettype wire

/* hdl/eth_stats_wb_regs.sv */
// Wishbone classic register file for the Ethernet statistics block.
// Holds the control register, reports the update tags and serves the
// 64-bit totals as lo/hi word pairs through a shared snapshot register.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_wb_regs import eth_stats_reg_pkg::*, eth_stats_frame_pkg::*; #(
	parameter int counter_width = 64
) (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [wb_addr_width-1:0] wb_adr,
	input  logic [wb_data_width-1:0] wb_dat_w,
	output logic [wb_data_width-1:0] wb_dat_r,
	output logic                     wb_ack,

	output logic                     enable,
	output logic                     srst,

	input  logic [tag_width-1:0]     tx_id,
	input  logic [tag_width-1:0]     rx_id,
	input  logic [counter_width-1:0] tx_bytes,
	input  logic [counter_width-1:0] tx_good,
	input  logic [counter_width-1:0] tx_bad,
	input  logic [counter_width-1:0] rx_bytes,
	input  logic [counter_width-1:0] rx_good,
	input  logic [counter_width-1:0] rx_bad
);

	// Width of the upper part of a total, as kept in the snapshot.
	localparam int hi_width = counter_width - wb_data_width;

	logic                     pending;
	logic [wb_data_width-1:0] rd_word;
	logic [wb_data_width-1:0] hi_word;
	logic                     snap_load;
	logic [hi_width-1:0]      snap_next;
	logic [hi_width-1:0]      snapshot;

	// A cycle is pending until it has been acked. Dropping ack in the cycle
	// after it makes a held strobe get acked every second cycle.
	assign pending = wb_cyc & wb_stb & ~wb_ack;

	assign hi_word = wb_data_width'(snapshot);

	////////////////////////////////////////////////////////////////////////////
	// Read decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word   = '0;
		snap_load = 1'b0;
		snap_next = snapshot;
		case (wb_adr)
			reg_ctrl: begin
				rd_word[ctrl_enable_bit] = enable;
			end
			reg_status: begin
				rd_word[status_tx_lsb +: tag_width] = tx_id;
				rd_word[status_rx_lsb +: tag_width] = rx_id;
			end
			// Each lo read also captures the upper part of the same total.
			reg_tx_bytes_lo: begin
				rd_word   = tx_bytes[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = tx_bytes[counter_width-1:wb_data_width];
			end
			reg_tx_good_lo: begin
				rd_word   = tx_good[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = tx_good[counter_width-1:wb_data_width];
			end
			reg_tx_bad_lo: begin
				rd_word   = tx_bad[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = tx_bad[counter_width-1:wb_data_width];
			end
			reg_rx_bytes_lo: begin
				rd_word   = rx_bytes[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = rx_bytes[counter_width-1:wb_data_width];
			end
			reg_rx_good_lo: begin
				rd_word   = rx_good[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = rx_good[counter_width-1:wb_data_width];
			end
			reg_rx_bad_lo: begin
				rd_word   = rx_bad[wb_data_width-1:0];
				snap_load = 1'b1;
				snap_next = rx_bad[counter_width-1:wb_data_width];
			end
			reg_tx_bytes_hi, reg_tx_good_hi, reg_tx_bad_hi,
			reg_rx_bytes_hi, reg_rx_good_hi, reg_rx_bad_hi: begin
				rd_word = hi_word;
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus handshake and control register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			enable <= 1'b0;
			srst   <= 1'b0;
		end else begin
			wb_ack <= pending;
			srst   <= 1'b0;
			// Writes anywhere but the control register are acked and dropped.
			if (pending && wb_we && wb_adr == reg_ctrl) begin
				enable <= wb_dat_w[ctrl_enable_bit];
				srst   <= wb_dat_w[ctrl_srst_bit];
			end
		end
	end

	// Read data is presented together with ack.
	always_ff @(posedge clk) begin
		if (pending) begin
			wb_dat_r <= rd_word;
		end
		if (pending && !wb_we && snap_load) begin
			snapshot <= snap_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/eth_stats_adder.sv */
// Per-direction statistics accumulator.
// Keeps the byte, good frame and bad frame totals and a wrapping update tag.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_adder import eth_stats_frame_pkg::*; #(
	parameter int counter_width = 64
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       enable,

	input  logic                       valid,
	input  logic                       frame_good,
	input  logic [frame_len_width-1:0] frame_length,

	output logic [counter_width-1:0]   total_bytes,
	output logic [counter_width-1:0]   total_good,
	output logic [counter_width-1:0]   total_bad,
	output logic [tag_width-1:0]       stats_id
);

	logic                     count_frame;
	logic [counter_width-1:0] length_ext;

	// Frames reported while counting is stopped are simply lost.
	assign count_frame = valid & enable;

	// Zero extension of the frame length to the width of the totals.
	assign length_ext = counter_width'(frame_length);

	////////////////////////////////////////////////////////////////////////////
	// Totals
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			total_bytes <= '0;
			total_good  <= '0;
			total_bad   <= '0;
			stats_id    <= '0;
		end else if (count_frame) begin
			// Bad frames still moved bytes on the wire, so they count here too.
			total_bytes <= total_bytes + length_ext;
			if (frame_good) begin
				total_good <= total_good + counter_width'(1);
			end else begin
				total_bad <= total_bad + counter_width'(1);
			end
			// The tag wraps at its width.
			stats_id <= stats_id + tag_width'(1);
		end
	end

endmodule

`default_nettype wire

/* hdl/eth_stats_counter_rx.sv */
// Receive frame counter.
// Measures the length of each frame on the MAC receive stream and takes
// the MAC's own verdict from tuser on the tlast beat.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_counter_rx import eth_stats_frame_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       rx_tvalid,
	input  logic                       rx_tlast,
	input  logic                       rx_tuser,

	output logic [frame_len_width-1:0] frame_bytes,
	output logic                       frame_good,
	output logic                       valid
);

	logic                       last_beat;
	logic [frame_len_width-1:0] beat_count;

	// The receive stream has no ready, every valid beat is taken.
	assign last_beat = rx_tvalid & rx_tlast;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_count <= '0;
			valid      <= 1'b0;
		end else begin
			valid <= last_beat;
			if (last_beat) begin
				beat_count <= '0;
			end else if (rx_tvalid) begin
				beat_count <= beat_count + frame_len_width'(1);
			end
		end
	end

	// The MAC raises tuser on the last beat of a frame it rejected,
	// for instance on an FCS error.
	always_ff @(posedge clk) begin
		if (last_beat) begin
			frame_bytes <= beat_count + frame_len_width'(1);
			frame_good  <= ~rx_tuser;
		end
	end

endmodule

`default_nettype wire

/* hdl/eth_stats_counter_tx.sv */
// Transmit frame counter.
// Measures the length of each frame on the MAC transmit stream and flags
// frames whose tvalid dropped before tlast, which is an underrun.

`timescale 1ns/1ps
`default_nettype none

module eth_stats_counter_tx import eth_stats_frame_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic                       tx_tvalid,
	input  logic                       tx_tready,
	input  logic                       tx_tlast,

	output logic [frame_len_width-1:0] frame_bytes,
	output logic                       frame_good,
	output logic                       valid
);

	logic                       beat;
	logic                       in_frame;
	logic                       underrun;
	logic [frame_len_width-1:0] beat_count;

	assign beat = tx_tvalid & tx_tready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_frame   <= 1'b0;
			underrun   <= 1'b0;
			beat_count <= '0;
			valid      <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (beat && tx_tlast) begin
				// Close the frame and report it on the next cycle.
				in_frame   <= 1'b0;
				underrun   <= 1'b0;
				beat_count <= '0;
				valid      <= 1'b1;
			end else if (beat) begin
				in_frame   <= 1'b1;
				beat_count <= beat_count + frame_len_width'(1);
			end else if (in_frame && !tx_tvalid) begin
				// The MAC ran dry in the middle of a frame.
				underrun <= 1'b1;
			end
		end
	end

	// Length and verdict are captured on the tlast beat, alongside valid.
	always_ff @(posedge clk) begin
		if (beat && tx_tlast) begin
			frame_bytes <= beat_count + frame_len_width'(1);
			frame_good  <= ~underrun;
		end
	end

endmodule

`default_nettype wire

/* hdl/eth_stats_reg_pkg.sv */
// Ethernet statistics register map.
// Wishbone widths, word addresses, control bits and status field positions.

`default_nettype none

package eth_stats_reg_pkg;

	// Wishbone bus geometry. Addresses are word addresses.
	localparam int wb_data_width = 32;
	localparam int wb_addr_width = 4;

	////////////////////////////////////////////////////////////////////////////
	// Word addresses
	////////////////////////////////////////////////////////////////////////////

	localparam logic [wb_addr_width-1:0] reg_ctrl        = 4'd0;
	localparam logic [wb_addr_width-1:0] reg_status      = 4'd1;
	localparam logic [wb_addr_width-1:0] reg_tx_bytes_lo = 4'd2;
	localparam logic [wb_addr_width-1:0] reg_tx_bytes_hi = 4'd3;
	localparam logic [wb_addr_width-1:0] reg_tx_good_lo  = 4'd4;
	localparam logic [wb_addr_width-1:0] reg_tx_good_hi  = 4'd5;
	localparam logic [wb_addr_width-1:0] reg_tx_bad_lo   = 4'd6;
	localparam logic [wb_addr_width-1:0] reg_tx_bad_hi   = 4'd7;
	localparam logic [wb_addr_width-1:0] reg_rx_bytes_lo = 4'd8;
	localparam logic [wb_addr_width-1:0] reg_rx_bytes_hi = 4'd9;
	localparam logic [wb_addr_width-1:0] reg_rx_good_lo  = 4'd10;
	localparam logic [wb_addr_width-1:0] reg_rx_good_hi  = 4'd11;
	localparam logic [wb_addr_width-1:0] reg_rx_bad_lo   = 4'd12;
	localparam logic [wb_addr_width-1:0] reg_rx_bad_hi   = 4'd13;

	// Control register bits. The reset bit always reads back as zero.
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_srst_bit   = 1;

	// Status register fields, given by their lowest bit.
	// The transmit tag sits in bits 2 to 0, the receive tag in bits 5 to 3.
	localparam int status_tx_lsb = 0;
	localparam int status_rx_lsb = 3;

endpackage

`default_nettype wire

/* hdl/eth_stats_frame_pkg.sv */
// Ethernet statistics frame-side definitions.
// Widths shared by the frame counters and the per-direction adders.

`default_nettype none

package eth_stats_frame_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame measurement
	////////////////////////////////////////////////////////////////////////////

	// The MAC moves one byte per beat, so a beat count is a byte count.
	// Sixteen bits cover jumbo frames with room to spare.
	localparam int frame_len_width = 16;

	////////////////////////////////////////////////////////////////////////////
	// Update tags
	////////////////////////////////////////////////////////////////////////////

	// Each direction carries a small tag that advances once per counted frame.
	// Software compares two reads of the tag to see that totals have moved.
	// The tag wraps at its width.
	localparam int tag_width = 3;

endpackage

`default_nettype wire
